//--- src/knnPkg.sv
// ==================================================
// Shared widths and types of the k-nearest-neighbour
// search unit for 3-D points
// ==================================================
`default_nettype none

package knnPkg;

    // Unsigned coordinate per axis
    localparam int coordWidth = 8;
    // Candidate index within one search
    localparam int idxWidth   = 10;
    // Three squared 8-bit differences need 18 bits
    localparam int distWidth  = 18;

    typedef logic [coordWidth-1:0] coordT;
    typedef logic [idxWidth-1:0]   idxT;
    typedef logic [distWidth-1:0]  distT;

    // Unfilled slot, larger than any real distance
    localparam distT distEmpty = '1;

endpackage

`default_nettype wire

//--- src/distanceCalc.sv
// ==================================================
// Distance stage: holds the query point and computes
// squared distances in a two-stage elastic pipeline
// ==================================================
`default_nettype none

module distanceCalc (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          queryLoad,
    input  knnPkg::coordT queryX,
    input  knnPkg::coordT queryY,
    input  knnPkg::coordT queryZ,
    input  knnPkg::coordT candX,
    input  knnPkg::coordT candY,
    input  knnPkg::coordT candZ,
    input  knnPkg::idxT   candIdx,
    input  logic          candLast,
    input  logic          candValid,
    output logic          candReady,
    output knnPkg::idxT   distIdx,
    output knnPkg::distT  distValue,
    output logic          distLast,
    output logic          distValid,
    input  logic          distReady
);

    // Query point, zero after reset
    knnPkg::coordT queryRegX, queryRegY, queryRegZ;

    // Stage one: absolute differences
    logic          s1Valid;
    knnPkg::coordT s1DiffX, s1DiffY, s1DiffZ;
    knnPkg::idxT   s1Idx;
    logic          s1Last;
    logic          s1Ready;

    // Stage two: sum of squares
    logic          s2Valid;
    knnPkg::distT  s2Dist;
    knnPkg::idxT   s2Idx;
    logic          s2Last;
    logic          s2Ready;

    logic [2*knnPkg::coordWidth-1:0] sqX, sqY, sqZ;
    knnPkg::distT  sumSq;

    // ==================================================
    // Handshake and valid bits
    // ==================================================
    // A stage loads when empty or when its item leaves
    assign s2Ready   = !s2Valid || distReady;
    assign s1Ready   = !s1Valid || s2Ready;
    assign candReady = s1Ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            queryRegX <= '0;
            queryRegY <= '0;
            queryRegZ <= '0;
            s1Valid   <= 1'b0;
            s2Valid   <= 1'b0;
        end else begin
            if (queryLoad) begin
                queryRegX <= queryX;
                queryRegY <= queryY;
                queryRegZ <= queryZ;
            end
            if (s1Ready) begin
                s1Valid <= candValid;
            end
            if (s2Ready) begin
                s2Valid <= s1Valid;
            end
        end
    end

    // ==================================================
    // Datapath
    // ==================================================
    assign sqX   = s1DiffX * s1DiffX;
    assign sqY   = s1DiffY * s1DiffY;
    assign sqZ   = s1DiffZ * s1DiffZ;
    // Zero-extend before adding so the carry is kept
    assign sumSq = knnPkg::distT'(sqX) + knnPkg::distT'(sqY) + knnPkg::distT'(sqZ);

    always_ff @(posedge clk) begin
        if (candValid && s1Ready) begin
            s1DiffX <= (candX > queryRegX) ? candX - queryRegX : queryRegX - candX;
            s1DiffY <= (candY > queryRegY) ? candY - queryRegY : queryRegY - candY;
            s1DiffZ <= (candZ > queryRegZ) ? candZ - queryRegZ : queryRegZ - candZ;
            s1Idx   <= candIdx;
            s1Last  <= candLast;
        end
        if (s1Valid && s2Ready) begin
            s2Dist <= sumSq;
            s2Idx  <= s1Idx;
            s2Last <= s1Last;
        end
    end

    assign distValid = s2Valid;
    assign distValue = s2Dist;
    assign distIdx   = s2Idx;
    assign distLast  = s2Last;

endmodule

`default_nettype wire

//--- src/insertionSorter.sv
// ==================================================
// Insertion sorter: keeps the numNeighbors smallest
// distances of one search in ascending order
// ==================================================
`default_nettype none

module insertionSorter #(
    parameter int numNeighbors = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  knnPkg::idxT                            distIdx,
    input  knnPkg::distT                           distValue,
    input  logic                                   distLast,
    input  logic                                   distValid,
    output logic                                   distReady,
    output logic [numNeighbors*knnPkg::idxWidth-1:0]  sortIdx,
    output logic [numNeighbors*knnPkg::distWidth-1:0] sortDist,
    output logic                                   sortValid,
    input  logic                                   sortReady
);

    // Slot 0 holds the nearest entry
    knnPkg::idxT  idxArr  [numNeighbors];
    knnPkg::distT distArr [numNeighbors];

    // shiftIn[i] set when a slot below i took the newcomer
    logic [numNeighbors:0]   shiftIn;
    logic [numNeighbors-1:0] insertHere;

    logic inHs;
    logic outHs;

    // ==================================================
    // Handshake
    // ==================================================
    assign inHs      = distValid && distReady;
    assign outHs     = sortValid && sortReady;
    // Input stalls while a finished list waits
    assign distReady = !sortValid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sortValid <= 1'b0;
        end else if (outHs) begin
            sortValid <= 1'b0;
        end else if (inHs && distLast) begin
            // Last candidate closes the search
            sortValid <= 1'b1;
        end
    end

    // ==================================================
    // Slot array
    // ==================================================
    assign shiftIn[0] = 1'b0;

    genvar i;
    generate
        for (i = 0; i < numNeighbors; i++) begin : genSlot
            // Strictly greater, so equal distances keep arrival order
            assign insertHere[i] = !shiftIn[i] && (distArr[i] > distValue);
            assign shiftIn[i+1]  = shiftIn[i] || insertHere[i];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    idxArr[i]  <= '0;
                    distArr[i] <= knnPkg::distEmpty;
                end else if (outHs) begin
                    // Result taken, start clean
                    idxArr[i]  <= '0;
                    distArr[i] <= knnPkg::distEmpty;
                end else if (inHs) begin
                    if (insertHere[i]) begin
                        idxArr[i]  <= distIdx;
                        distArr[i] <= distValue;
                    end else if (shiftIn[i]) begin
                        // Move up by one, top slot drops out
                        if (i > 0) begin
                            idxArr[i]  <= idxArr[i-1];
                            distArr[i] <= distArr[i-1];
                        end
                    end
                end
            end

            assign sortIdx[i*knnPkg::idxWidth +: knnPkg::idxWidth]    = idxArr[i];
            assign sortDist[i*knnPkg::distWidth +: knnPkg::distWidth] = distArr[i];
        end
    endgenerate

endmodule

`default_nettype wire

//--- src/neighborSerializer.sv
// ==================================================
// Result serializer: sends the sorted neighbours one
// per beat, nearest first, last beat flagged
// ==================================================
`default_nettype none

module neighborSerializer #(
    parameter int numNeighbors = 4
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic [numNeighbors*knnPkg::idxWidth-1:0]  sortIdx,
    input  logic [numNeighbors*knnPkg::distWidth-1:0] sortDist,
    input  logic                                      sortValid,
    output logic                                      sortReady,
    output knnPkg::idxT                               nbrIdx,
    output knnPkg::distT                              nbrDist,
    output logic                                      nbrLast,
    output logic                                      nbrValid,
    input  logic                                      nbrReady
);

    // At least one counter bit, also for a single neighbour
    localparam int cntWidth = (numNeighbors > 1) ? $clog2(numNeighbors) : 1;
    localparam logic [cntWidth-1:0] lastCount = cntWidth'(numNeighbors - 1);

    // Local copy frees the sorter for the next search
    logic [numNeighbors*knnPkg::idxWidth-1:0]  idxHold;
    logic [numNeighbors*knnPkg::distWidth-1:0] distHold;
    logic [cntWidth-1:0] beatCount;
    logic loadHs;
    logic sendHs;

    assign sortReady = !nbrValid;
    assign loadHs    = sortValid && sortReady;
    assign sendHs    = nbrValid && nbrReady;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nbrValid  <= 1'b0;
            beatCount <= '0;
        end else if (loadHs) begin
            nbrValid  <= 1'b1;
            beatCount <= '0;
        end else if (sendHs) begin
            if (beatCount == lastCount) begin
                nbrValid <= 1'b0;
            end else begin
                beatCount <= beatCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loadHs) begin
            idxHold  <= sortIdx;
            distHold <= sortDist;
        end
    end

    // Counter picks the entry on the output
    assign nbrIdx  = idxHold[beatCount*knnPkg::idxWidth +: knnPkg::idxWidth];
    assign nbrDist = distHold[beatCount*knnPkg::distWidth +: knnPkg::distWidth];
    assign nbrLast = nbrValid && (beatCount == lastCount);

endmodule

`default_nettype wire

//--- src/knnSearch.sv
// ==================================================
// k-nearest-neighbour search unit, top level
// ==================================================
`default_nettype none

module knnSearch #(
    parameter int numNeighbors = 4
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          queryLoad,
    input  knnPkg::coordT queryX,
    input  knnPkg::coordT queryY,
    input  knnPkg::coordT queryZ,
    input  knnPkg::coordT candX,
    input  knnPkg::coordT candY,
    input  knnPkg::coordT candZ,
    input  knnPkg::idxT   candIdx,
    input  logic          candLast,
    input  logic          candValid,
    output logic          candReady,
    output knnPkg::idxT   nbrIdx,
    output knnPkg::distT  nbrDist,
    output logic          nbrLast,
    output logic          nbrValid,
    input  logic          nbrReady
);

    // Distance stage to sorter
    knnPkg::idxT  distIdx;
    knnPkg::distT distValue;
    logic         distLast;
    logic         distValid;
    logic         distReady;

    // Sorter to serializer, entry 0 nearest
    logic [numNeighbors*knnPkg::idxWidth-1:0]  sortIdx;
    logic [numNeighbors*knnPkg::distWidth-1:0] sortDist;
    logic sortValid;
    logic sortReady;

    distanceCalc distanceCalc_inst (
        .clk(clk), .rst_n(rst_n), .queryLoad(queryLoad),
        .queryX(queryX), .queryY(queryY), .queryZ(queryZ),
        .candX(candX), .candY(candY), .candZ(candZ), .candIdx(candIdx),
        .candLast(candLast), .candValid(candValid), .candReady(candReady),
        .distIdx(distIdx), .distValue(distValue), .distLast(distLast),
        .distValid(distValid), .distReady(distReady)
    );

    insertionSorter #(.numNeighbors(numNeighbors)) insertionSorter_inst (
        .clk(clk), .rst_n(rst_n),
        .distIdx(distIdx), .distValue(distValue), .distLast(distLast),
        .distValid(distValid), .distReady(distReady),
        .sortIdx(sortIdx), .sortDist(sortDist),
        .sortValid(sortValid), .sortReady(sortReady)
    );

    neighborSerializer #(.numNeighbors(numNeighbors)) neighborSerializer_inst (
        .clk(clk), .rst_n(rst_n),
        .sortIdx(sortIdx), .sortDist(sortDist),
        .sortValid(sortValid), .sortReady(sortReady),
        .nbrIdx(nbrIdx), .nbrDist(nbrDist), .nbrLast(nbrLast),
        .nbrValid(nbrValid), .nbrReady(nbrReady)
    );

endmodule

`default_nettype wire

//--- bench/knnSearchTb.sv
// ==================================================
// Table-driven testbench of the kNN search unit with
// searches checked against a reference model
// ==================================================
`default_nettype none

module knnSearchTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int numNeighbors = 4;
    localparam int numRows      = 5;
    localparam int maxCands     = 16;
    // Extra cycles per row for gaps, stalls and latency
    localparam int stallAllow   = 16;

    logic          clk;
    logic          rst_n;
    logic          queryLoad;
    knnPkg::coordT queryX, queryY, queryZ;
    knnPkg::coordT candX, candY, candZ;
    knnPkg::idxT   candIdx;
    logic          candLast, candValid, candReady;
    knnPkg::idxT   nbrIdx;
    knnPkg::distT  nbrDist;
    logic          nbrLast, nbrValid, nbrReady;

    // ==================================================
    // Stimulus table, one search per row
    // ==================================================
    string      rowName  [numRows] = '{"basic", "short", "ties", "backPressure", "backToBack"};
    int         rowQx    [numRows] = '{50, 10, 100, 128, 200};
    int         rowQy    [numRows] = '{60, 20, 100, 128, 5};
    int         rowQz    [numRows] = '{70, 30, 100, 128, 90};
    int         rowCount [numRows] = '{12, 2, 6, 16, 9};
    bit         rowFixed [numRows] = '{0, 0, 1, 0, 0};
    // A set gap bit idles the cycle before that candidate
    logic [7:0] rowGap   [numRows] = '{8'h00, 8'h00, 8'h00, 8'hB2, 8'h00};
    // A set stall bit holds nbrReady low in that cycle
    logic [7:0] rowStall [numRows] = '{8'h00, 8'h00, 8'h00, 8'h69, 8'h00};

    // Fixed points around (100,100,100) with ties at 9 and one nearer point
    int fixX [6] = '{103, 100, 110, 100, 101, 100};
    int fixY [6] = '{100,  97, 100, 100, 100, 100};
    int fixZ [6] = '{100, 100, 100,  97, 100, 103};

    int candXs [maxCands];
    int candYs [maxCands];
    int candZs [maxCands];
    knnPkg::idxT  expIdx  [numNeighbors];
    knnPkg::distT expDist [numNeighbors];

    int seed;
    int idxErrors;
    int distErrors;
    int protoErrors;
    int cycleCount = 0;
    int cycleLimit = 0;

    knnSearch #(.numNeighbors(numNeighbors)) knnSearch_inst (
        .clk(clk), .rst_n(rst_n), .queryLoad(queryLoad),
        .queryX(queryX), .queryY(queryY), .queryZ(queryZ),
        .candX(candX), .candY(candY), .candZ(candZ), .candIdx(candIdx),
        .candLast(candLast), .candValid(candValid), .candReady(candReady),
        .nbrIdx(nbrIdx), .nbrDist(nbrDist), .nbrLast(nbrLast),
        .nbrValid(nbrValid), .nbrReady(nbrReady)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Watchdog on total cycles
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycleCount);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // 2 ns past the next rising edge
    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic checkIdx(string testName, knnPkg::idxT expected, knnPkg::idxT actual);
        if (actual !== expected) begin
            $display("Error %s: index expected %0d, actual %0d", testName, expected, actual);
            idxErrors++;
        end
    endtask

    task automatic checkDist(string testName, knnPkg::distT expected, knnPkg::distT actual);
        if (actual !== expected) begin
            $display("Error %s: distance expected %0d, actual %0d", testName, expected, actual);
            distErrors++;
        end
    endtask

    task automatic checkLast(string testName, int beat, logic last);
        if (last && beat < numNeighbors - 1) begin
            $display("%s: nbrLast came early, on beat %0d", testName, beat);
            protoErrors++;
        end else if (!last && beat == numNeighbors - 1) begin
            $display("%s: nbrLast missing on the final beat", testName);
            protoErrors++;
        end
    endtask

    // ==================================================
    // Reference model that keeps equal distances in arrival order
    // ==================================================
    task automatic buildExpected(int row);
        int dx;
        int dy;
        int dz;
        int p;
        knnPkg::distT d;
        for (int k = 0; k < numNeighbors; k++) begin
            expIdx[k]  = '0;
            expDist[k] = knnPkg::distEmpty;
        end
        for (int c = 0; c < rowCount[row]; c++) begin
            dx = candXs[c] - rowQx[row];
            dy = candYs[c] - rowQy[row];
            dz = candZs[c] - rowQz[row];
            d  = knnPkg::distT'(dx * dx + dy * dy + dz * dz);
            // First slot holding a strictly larger distance
            p = 0;
            while (p < numNeighbors && expDist[p] <= d) p++;
            for (int s = numNeighbors - 1; s > p; s--) begin
                expIdx[s]  = expIdx[s-1];
                expDist[s] = expDist[s-1];
            end
            if (p < numNeighbors) begin
                expIdx[p]  = knnPkg::idxT'(c);
                expDist[p] = d;
            end
        end
    endtask

    task automatic loadQuery(int row);
        queryX    = knnPkg::coordT'(rowQx[row]);
        queryY    = knnPkg::coordT'(rowQy[row]);
        queryZ    = knnPkg::coordT'(rowQz[row]);
        queryLoad = 1'b1;
        nextCycle();
        queryLoad = 1'b0;
    endtask

    task automatic sendCandidates(int row);
        for (int c = 0; c < rowCount[row]; c++) begin
            if (rowGap[row][c % 8]) begin
                candValid = 1'b0;
                nextCycle();
            end
            candX     = knnPkg::coordT'(candXs[c]);
            candY     = knnPkg::coordT'(candYs[c]);
            candZ     = knnPkg::coordT'(candZs[c]);
            candIdx   = knnPkg::idxT'(c);
            candLast  = (c == rowCount[row] - 1);
            candValid = 1'b1;
            // Hold the beat until the DUT takes it
            #1;
            while (!candReady) begin
                nextCycle();
                #1;
            end
            nextCycle();
        end
        candValid = 1'b0;
        candLast  = 1'b0;
    endtask

    task automatic collectResult(int row);
        int beat;
        int cyc;
        beat = 0;
        cyc  = 0;
        while (beat < numNeighbors) begin
            nbrReady = !rowStall[row][cyc % 8];
            #1;
            if (nbrValid && nbrReady) begin
                checkIdx(rowName[row], expIdx[beat], nbrIdx);
                checkDist(rowName[row], expDist[beat], nbrDist);
                checkLast(rowName[row], beat, nbrLast);
                beat++;
            end
            cyc++;
            nextCycle();
        end
        nbrReady = 1'b0;
        // A fifth beat would be a repeat
        if (nbrValid) begin
            $display("%s: nbrValid still high after the final neighbour", rowName[row]);
            protoErrors++;
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        seed        = 87;
        idxErrors   = 0;
        distErrors  = 0;
        protoErrors = 0;
        for (int r = 0; r < numRows; r++) begin
            cycleLimit += (rowCount[r] + numNeighbors + stallAllow) * 4;
        end
        rst_n     = 1'b0;
        queryLoad = 1'b0;
        queryX    = '0;
        queryY    = '0;
        queryZ    = '0;
        candX     = '0;
        candY     = '0;
        candZ     = '0;
        candIdx   = '0;
        candLast  = 1'b0;
        candValid = 1'b0;
        nbrReady  = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        #1;
        if (candReady !== 1'b1 || nbrValid !== 1'b0) begin
            $display("Reset state wrong: candReady should be high and nbrValid low");
            protoErrors++;
        end
        nextCycle();
        for (int r = 0; r < numRows; r++) begin
            for (int c = 0; c < rowCount[r]; c++) begin
                if (rowFixed[r]) begin
                    candXs[c] = fixX[c];
                    candYs[c] = fixY[c];
                    candZs[c] = fixZ[c];
                end else begin
                    candXs[c] = $random(seed) & 255;
                    candYs[c] = $random(seed) & 255;
                    candZs[c] = $random(seed) & 255;
                end
            end
            buildExpected(r);
            loadQuery(r);
            sendCandidates(r);
            collectResult(r);
        end
        $display("Index errors: %0d, distance errors: %0d, protocol errors: %0d",
                 idxErrors, distErrors, protoErrors);
        if (idxErrors + distErrors + protoErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
src/knnPkg.sv
src/distanceCalc.sv
src/insertionSorter.sv
src/neighborSerializer.sv
src/knnSearch.sv
bench/knnSearchTb.sv

//--- run.sh
#!/bin/sh
# Build the kNN search testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module knnSearchTb -o knnSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/knnSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only if the testbench printed its pass line
if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi
